// ==== hw/ooo_pkg.sv ====
package ooo_pkg;

    localparam int XLEN  = 32;
    localparam int TAG_W = 6;   // Tag 0 is no register
    localparam int N     = 2;   // Dispatch width and CDB lanes

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_kind_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        XOR,
        MUL
    } alu_func_e;

    // Source operand, a tag while waiting and the value once ready
    typedef union packed {
        logic [XLEN-1:0] value;
        struct packed {
            logic [XLEN-TAG_W-1:0] pad;
            logic [TAG_W-1:0]      tag;
        } src;
    } operand_u;

endpackage

// ==== hw/psel_gen.sv ====
`timescale 1ns/1ns

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 1
) (
    input  logic [WIDTH-1:0]           req,
    output logic [WIDTH-1:0]           gnt,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    always_comb begin
        logic [WIDTH-1:0] left;
        logic             hit;
        int               idx;
        left    = req;
        gnt_bus = '0;
        for (int r = 0; r < REQS; r++) begin
            hit = 1'b0;
            // Even grants scan from the bottom, odd ones from the top
            for (int k = 0; k < WIDTH; k++) begin
                idx = (r % 2 == 0) ? k : WIDTH - 1 - k;
                if (!hit && left[idx]) begin
                    gnt_bus[r][idx] = 1'b1;
                    left[idx]       = 1'b0;   // Never granted twice
                    hit             = 1'b1;
                end
            end
        end
    end

    always_comb begin
        gnt = '0;
        for (int r = 0; r < REQS; r++) begin
            gnt = gnt | gnt_bus[r];
        end
    end

    assign empty = ~|req;

endmodule

// ==== hw/rs.sv ====
`timescale 1ns/1ns

module rs #(
    parameter int SIZE        = 8,
    parameter int ALERT_DEPTH = 2,
    parameter int NUM_ALU     = 2
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [ooo_pkg::N-1:0]                     dispatch_valid,
    input  ooo_pkg::fu_kind_e [ooo_pkg::N-1:0]        dispatch_fu,
    input  ooo_pkg::alu_func_e [ooo_pkg::N-1:0]       dispatch_func,
    input  logic [ooo_pkg::N-1:0]                     op1_ready,
    input  ooo_pkg::operand_u [ooo_pkg::N-1:0]        op1,
    input  logic [ooo_pkg::N-1:0]                     op2_ready,
    input  ooo_pkg::operand_u [ooo_pkg::N-1:0]        op2,
    input  logic [ooo_pkg::N-1:0][ooo_pkg::TAG_W-1:0] dest_tag,
    input  logic [ooo_pkg::N-1:0]                     cdb_valid,
    input  logic [ooo_pkg::N-1:0][ooo_pkg::TAG_W-1:0] cdb_tag,
    input  logic [ooo_pkg::N-1:0][ooo_pkg::XLEN-1:0]  cdb_value,
    input  logic [NUM_ALU-1:0]                        alu_avail,
    input  logic                                      mult_avail,
    output logic [NUM_ALU-1:0]                        alu_issue_valid,
    output ooo_pkg::alu_func_e [NUM_ALU-1:0]          alu_issue_func,
    output logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0]     alu_issue_a,
    output logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0]     alu_issue_b,
    output logic [NUM_ALU-1:0][ooo_pkg::TAG_W-1:0]    alu_issue_tag,
    output logic                                      mult_issue_valid,
    output ooo_pkg::alu_func_e                        mult_issue_func,
    output logic [ooo_pkg::XLEN-1:0]                  mult_issue_a,
    output logic [ooo_pkg::XLEN-1:0]                  mult_issue_b,
    output logic [ooo_pkg::TAG_W-1:0]                 mult_issue_tag,
    output logic                                      almost_full
);
    localparam int CNT_W = $clog2(SIZE + 1);

    logic [CNT_W-1:0]                    count;
    logic [CNT_W-1:0]                    nxt_count;
    logic [SIZE-1:0]                     ent_valid;
    logic [SIZE-1:0]                     nxt_valid;
    ooo_pkg::fu_kind_e [SIZE-1:0]        ent_fu;
    ooo_pkg::fu_kind_e [SIZE-1:0]        nxt_fu;
    ooo_pkg::alu_func_e [SIZE-1:0]       ent_func;
    ooo_pkg::alu_func_e [SIZE-1:0]       nxt_func;
    logic [SIZE-1:0]                     ent_rdy1;
    logic [SIZE-1:0]                     nxt_rdy1;
    logic [SIZE-1:0]                     ent_rdy2;
    logic [SIZE-1:0]                     nxt_rdy2;
    ooo_pkg::operand_u [SIZE-1:0]        ent_op1;
    ooo_pkg::operand_u [SIZE-1:0]        nxt_op1;
    ooo_pkg::operand_u [SIZE-1:0]        ent_op2;
    ooo_pkg::operand_u [SIZE-1:0]        nxt_op2;
    logic [SIZE-1:0][ooo_pkg::TAG_W-1:0] ent_dest;
    logic [SIZE-1:0][ooo_pkg::TAG_W-1:0] nxt_dest;

    logic [SIZE-1:0]              alu_req;
    logic [SIZE-1:0]              mult_req;
    logic [NUM_ALU-1:0][SIZE-1:0] alu_gnt_bus;
    logic [SIZE-1:0]              mult_gnt;

    logic [NUM_ALU-1:0]                    nxt_alu_valid;
    ooo_pkg::alu_func_e [NUM_ALU-1:0]      nxt_alu_func;
    logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0] nxt_alu_a;
    logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0] nxt_alu_b;
    logic [NUM_ALU-1:0][ooo_pkg::TAG_W-1:0] nxt_alu_tag;
    logic                                  nxt_mult_valid;
    ooo_pkg::alu_func_e                    nxt_mult_func;
    logic [ooo_pkg::XLEN-1:0]              nxt_mult_a;
    logic [ooo_pkg::XLEN-1:0]              nxt_mult_b;
    logic [ooo_pkg::TAG_W-1:0]             nxt_mult_tag;

    psel_gen #(.WIDTH(SIZE), .REQS(NUM_ALU)) alu_selector (
        .req     (alu_req),
        .gnt     (),
        .gnt_bus (alu_gnt_bus),
        .empty   ()
    );

    psel_gen #(.WIDTH(SIZE), .REQS(1)) mult_selector (
        .req     (mult_req),
        .gnt     (mult_gnt),
        .gnt_bus (),
        .empty   ()
    );

    always_comb begin
        for (int i = 0; i < SIZE; i++) begin
            alu_req[i]  = ent_valid[i] && ent_rdy1[i] && ent_rdy2[i]
                          && (ent_fu[i] == ooo_pkg::FU_ALU);
            mult_req[i] = ent_valid[i] && ent_rdy1[i] && ent_rdy2[i]
                          && (ent_fu[i] == ooo_pkg::FU_MULT);
        end
    end

    assign almost_full = count > CNT_W'(SIZE - ALERT_DEPTH);

    always_comb begin
        logic [SIZE-1:0] free;
        logic            placed;
        free      = ~ent_valid;
        nxt_count = count;
        nxt_valid = ent_valid;
        nxt_fu    = ent_fu;
        nxt_func  = ent_func;
        nxt_rdy1  = ent_rdy1;
        nxt_rdy2  = ent_rdy2;
        nxt_op1   = ent_op1;
        nxt_op2   = ent_op2;
        nxt_dest  = ent_dest;

        nxt_alu_valid  = '0;
        nxt_alu_func   = alu_issue_func;
        nxt_alu_a      = alu_issue_a;
        nxt_alu_b      = alu_issue_b;
        nxt_alu_tag    = alu_issue_tag;
        nxt_mult_valid = 1'b0;
        nxt_mult_func  = mult_issue_func;
        nxt_mult_a     = mult_issue_a;
        nxt_mult_b     = mult_issue_b;
        nxt_mult_tag   = mult_issue_tag;

        // Each lane takes the lowest entry still free
        for (int k = 0; k < ooo_pkg::N; k++) begin
            placed = 1'b0;
            for (int i = 0; i < SIZE; i++) begin
                if (!placed && free[i] && dispatch_valid[k] && !almost_full) begin
                    free[i]     = 1'b0;
                    placed      = 1'b1;
                    nxt_valid[i] = 1'b1;
                    nxt_fu[i]   = dispatch_fu[k];
                    nxt_func[i] = dispatch_func[k];
                    nxt_rdy1[i] = op1_ready[k];
                    nxt_rdy2[i] = op2_ready[k];
                    nxt_op1[i]  = op1[k];
                    nxt_op2[i]  = op2[k];
                    nxt_dest[i] = dest_tag[k];
                    nxt_count   = nxt_count + 1'b1;
                end
            end
        end

        // Wake-up sees entries written above too
        for (int i = 0; i < SIZE; i++) begin
            for (int c = 0; c < ooo_pkg::N; c++) begin
                if (cdb_valid[c]) begin
                    if (!nxt_rdy1[i] && nxt_op1[i].src.tag == cdb_tag[c]) begin
                        nxt_rdy1[i]      = 1'b1;
                        nxt_op1[i].value = cdb_value[c];
                    end
                    if (!nxt_rdy2[i] && nxt_op2[i].src.tag == cdb_tag[c]) begin
                        nxt_rdy2[i]      = 1'b1;
                        nxt_op2[i].value = cdb_value[c];
                    end
                end
            end
        end

        for (int i = 0; i < SIZE; i++) begin
            for (int j = 0; j < NUM_ALU; j++) begin
                if (alu_gnt_bus[j][i] && alu_avail[j]) begin
                    nxt_alu_valid[j] = 1'b1;
                    nxt_alu_func[j]  = ent_func[i];
                    nxt_alu_a[j]     = ent_op1[i].value;
                    nxt_alu_b[j]     = ent_op2[i].value;
                    nxt_alu_tag[j]   = ent_dest[i];
                    nxt_valid[i]     = 1'b0;
                    nxt_count        = nxt_count - 1'b1;
                end
            end
            if (mult_gnt[i] && mult_avail) begin
                nxt_mult_valid = 1'b1;
                nxt_mult_func  = ent_func[i];
                nxt_mult_a     = ent_op1[i].value;
                nxt_mult_b     = ent_op2[i].value;
                nxt_mult_tag   = ent_dest[i];
                nxt_valid[i]   = 1'b0;
                nxt_count      = nxt_count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count            <= '0;
            ent_valid        <= '0;
            alu_issue_valid  <= '0;
            mult_issue_valid <= 1'b0;
        end else begin
            count            <= nxt_count;
            ent_valid        <= nxt_valid;
            alu_issue_valid  <= nxt_alu_valid;
            mult_issue_valid <= nxt_mult_valid;
        end
    end

    always_ff @(posedge clock) begin
        ent_fu          <= nxt_fu;
        ent_func        <= nxt_func;
        ent_rdy1        <= nxt_rdy1;
        ent_rdy2        <= nxt_rdy2;
        ent_op1         <= nxt_op1;
        ent_op2         <= nxt_op2;
        ent_dest        <= nxt_dest;
        alu_issue_func  <= nxt_alu_func;
        alu_issue_a     <= nxt_alu_a;
        alu_issue_b     <= nxt_alu_b;
        alu_issue_tag   <= nxt_alu_tag;
        mult_issue_func <= nxt_mult_func;
        mult_issue_a    <= nxt_mult_a;
        mult_issue_b    <= nxt_mult_b;
        mult_issue_tag  <= nxt_mult_tag;
    end

endmodule

// ==== hw/alu_fu.sv ====
`timescale 1ns/1ns

module alu_fu (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  ooo_pkg::alu_func_e        issue_func,
    input  logic [ooo_pkg::XLEN-1:0]  issue_a,
    input  logic [ooo_pkg::XLEN-1:0]  issue_b,
    input  logic [ooo_pkg::TAG_W-1:0] issue_tag,
    input  logic                      taken,
    output logic                      avail,
    output logic                      done,
    output logic [ooo_pkg::XLEN-1:0]  result,
    output logic [ooo_pkg::TAG_W-1:0] tag
);
    logic [ooo_pkg::XLEN-1:0] alu_out;

    always_comb begin
        case (issue_func)
            ooo_pkg::SUB: alu_out = issue_a - issue_b;
            ooo_pkg::AND: alu_out = issue_a & issue_b;
            ooo_pkg::XOR: alu_out = issue_a ^ issue_b;
            default:      alu_out = issue_a + issue_b;
        endcase
    end

    // A packet on its way also needs the result register next cycle
    assign avail = !issue_valid && !(done && !taken);

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else if (issue_valid) begin
            done <= 1'b1;
        end else if (taken) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            result <= alu_out;
            tag    <= issue_tag;
        end
    end

endmodule

// ==== hw/mult_fu.sv ====
`timescale 1ns/1ns

module mult_fu #(
    parameter int MULT_STAGES = 3
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      issue_valid,
    input  ooo_pkg::alu_func_e        issue_func,
    input  logic [ooo_pkg::XLEN-1:0]  issue_a,
    input  logic [ooo_pkg::XLEN-1:0]  issue_b,
    input  logic [ooo_pkg::TAG_W-1:0] issue_tag,
    input  logic                      taken,
    output logic                      avail,
    output logic                      done,
    output logic [ooo_pkg::XLEN-1:0]  result,
    output logic [ooo_pkg::TAG_W-1:0] tag
);
    logic [MULT_STAGES-1:0]                     stage_valid;
    logic [MULT_STAGES-1:0][ooo_pkg::TAG_W-1:0] stage_tag;
    logic [MULT_STAGES-1:0][ooo_pkg::XLEN-1:0]  stage_prod;
    logic                                       stall;

    // Top CDB priority keeps the stall rare
    assign stall  = stage_valid[MULT_STAGES-1] && !taken;
    assign avail  = !stall;
    assign done   = stage_valid[MULT_STAGES-1];
    assign result = stage_prod[MULT_STAGES-1];
    assign tag    = stage_tag[MULT_STAGES-1];

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (!stall) begin
            stage_valid[0] <= issue_valid && (issue_func == ooo_pkg::MUL);
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            stage_prod[0] <= issue_a * issue_b;   // Low word only
            stage_tag[0]  <= issue_tag;
            for (int s = 1; s < MULT_STAGES; s++) begin
                stage_prod[s] <= stage_prod[s-1];
                stage_tag[s]  <= stage_tag[s-1];
            end
        end
    end

endmodule

// ==== hw/cdb_arb.sv ====
`timescale 1ns/1ns

module cdb_arb #(
    parameter int NUM_ALU = 2
) (
    input  logic [NUM_ALU-1:0]                        alu_done,
    input  logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0]     alu_result,
    input  logic [NUM_ALU-1:0][ooo_pkg::TAG_W-1:0]    alu_tag,
    input  logic                                      mult_done,
    input  logic [ooo_pkg::XLEN-1:0]                  mult_result,
    input  logic [ooo_pkg::TAG_W-1:0]                 mult_tag,
    output logic [NUM_ALU-1:0]                        alu_taken,
    output logic                                      mult_taken,
    output logic [ooo_pkg::N-1:0]                     cdb_valid,
    output logic [ooo_pkg::N-1:0][ooo_pkg::TAG_W-1:0] cdb_tag,
    output logic [ooo_pkg::N-1:0][ooo_pkg::XLEN-1:0]  cdb_value
);

    always_comb begin
        int lane;
        lane       = 0;
        cdb_valid  = '0;
        cdb_tag    = '0;
        cdb_value  = '0;
        alu_taken  = '0;
        mult_taken = 1'b0;

        if (mult_done) begin   // Multiplier always wins lane 0
            cdb_valid[0] = 1'b1;
            cdb_tag[0]   = mult_tag;
            cdb_value[0] = mult_result;
            mult_taken   = 1'b1;
            lane         = 1;
        end

        for (int j = 0; j < NUM_ALU; j++) begin
            if (alu_done[j] && lane < ooo_pkg::N) begin
                cdb_valid[lane] = 1'b1;
                cdb_tag[lane]   = alu_tag[j];
                cdb_value[lane] = alu_result[j];
                alu_taken[j]    = 1'b1;
                lane            = lane + 1;
            end
        end
    end

endmodule

// ==== hw/issue_core.sv ====
`timescale 1ns/1ns

module issue_core #(
    parameter int SIZE        = 8,
    parameter int ALERT_DEPTH = ooo_pkg::N,
    parameter int NUM_ALU     = 2,
    parameter int MULT_STAGES = 3
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic [ooo_pkg::N-1:0]                     dispatch_valid,
    input  ooo_pkg::fu_kind_e [ooo_pkg::N-1:0]        dispatch_fu,
    input  ooo_pkg::alu_func_e [ooo_pkg::N-1:0]       dispatch_func,
    input  logic [ooo_pkg::N-1:0]                     op1_ready,
    input  ooo_pkg::operand_u [ooo_pkg::N-1:0]        op1,
    input  logic [ooo_pkg::N-1:0]                     op2_ready,
    input  ooo_pkg::operand_u [ooo_pkg::N-1:0]        op2,
    input  logic [ooo_pkg::N-1:0][ooo_pkg::TAG_W-1:0] dest_tag,
    output logic                                      almost_full,
    output logic [ooo_pkg::N-1:0]                     cdb_valid,
    output logic [ooo_pkg::N-1:0][ooo_pkg::TAG_W-1:0] cdb_tag,
    output logic [ooo_pkg::N-1:0][ooo_pkg::XLEN-1:0]  cdb_value
);
    logic [NUM_ALU-1:0]                     alu_issue_valid;
    ooo_pkg::alu_func_e [NUM_ALU-1:0]       alu_issue_func;
    logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0]  alu_issue_a;
    logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0]  alu_issue_b;
    logic [NUM_ALU-1:0][ooo_pkg::TAG_W-1:0] alu_issue_tag;
    logic [NUM_ALU-1:0]                     alu_avail;
    logic [NUM_ALU-1:0]                     alu_done;
    logic [NUM_ALU-1:0][ooo_pkg::XLEN-1:0]  alu_result;
    logic [NUM_ALU-1:0][ooo_pkg::TAG_W-1:0] alu_tag;
    logic [NUM_ALU-1:0]                     alu_taken;

    logic                      mult_issue_valid;
    ooo_pkg::alu_func_e        mult_issue_func;
    logic [ooo_pkg::XLEN-1:0]  mult_issue_a;
    logic [ooo_pkg::XLEN-1:0]  mult_issue_b;
    logic [ooo_pkg::TAG_W-1:0] mult_issue_tag;
    logic                      mult_avail;
    logic                      mult_done;
    logic [ooo_pkg::XLEN-1:0]  mult_result;
    logic [ooo_pkg::TAG_W-1:0] mult_tag;
    logic                      mult_taken;

    rs #(
        .SIZE        (SIZE),
        .ALERT_DEPTH (ALERT_DEPTH),
        .NUM_ALU     (NUM_ALU)
    ) u_rs (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid   (dispatch_valid),
        .dispatch_fu      (dispatch_fu),
        .dispatch_func    (dispatch_func),
        .op1_ready        (op1_ready),
        .op1              (op1),
        .op2_ready        (op2_ready),
        .op2              (op2),
        .dest_tag         (dest_tag),
        .cdb_valid        (cdb_valid),   // CDB loop-back
        .cdb_tag          (cdb_tag),
        .cdb_value        (cdb_value),
        .alu_avail        (alu_avail),
        .mult_avail       (mult_avail),
        .alu_issue_valid  (alu_issue_valid),
        .alu_issue_func   (alu_issue_func),
        .alu_issue_a      (alu_issue_a),
        .alu_issue_b      (alu_issue_b),
        .alu_issue_tag    (alu_issue_tag),
        .mult_issue_valid (mult_issue_valid),
        .mult_issue_func  (mult_issue_func),
        .mult_issue_a     (mult_issue_a),
        .mult_issue_b     (mult_issue_b),
        .mult_issue_tag   (mult_issue_tag),
        .almost_full      (almost_full)
    );

    for (genvar j = 0; j < NUM_ALU; j++) begin : g_alu
        alu_fu u_alu (
            .clock       (clock),
            .reset       (reset),
            .issue_valid (alu_issue_valid[j]),
            .issue_func  (alu_issue_func[j]),
            .issue_a     (alu_issue_a[j]),
            .issue_b     (alu_issue_b[j]),
            .issue_tag   (alu_issue_tag[j]),
            .taken       (alu_taken[j]),
            .avail       (alu_avail[j]),
            .done        (alu_done[j]),
            .result      (alu_result[j]),
            .tag         (alu_tag[j])
        );
    end

    mult_fu #(.MULT_STAGES(MULT_STAGES)) u_mult (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (mult_issue_valid),
        .issue_func  (mult_issue_func),
        .issue_a     (mult_issue_a),
        .issue_b     (mult_issue_b),
        .issue_tag   (mult_issue_tag),
        .taken       (mult_taken),
        .avail       (mult_avail),
        .done        (mult_done),
        .result      (mult_result),
        .tag         (mult_tag)
    );

    cdb_arb #(.NUM_ALU(NUM_ALU)) u_arb (
        .alu_done    (alu_done),
        .alu_result  (alu_result),
        .alu_tag     (alu_tag),
        .mult_done   (mult_done),
        .mult_result (mult_result),
        .mult_tag    (mult_tag),
        .alu_taken   (alu_taken),
        .mult_taken  (mult_taken),
        .cdb_valid   (cdb_valid),
        .cdb_tag     (cdb_tag),
        .cdb_value   (cdb_value)
    );

endmodule

// ==== testbench/issue_core_chk.sv ====
`timescale 1ns/1ns

module issue_core_chk (
    input logic                                      clock,
    input logic                                      reset,
    input logic                                      almost_full,
    input logic [ooo_pkg::N-1:0]                     cdb_valid,
    input logic [ooo_pkg::N-1:0][ooo_pkg::TAG_W-1:0] cdb_tag
);

    for (genvar k = 0; k < ooo_pkg::N; k++) begin : g_lane
        a_no_tag0: assert property (@(posedge clock) disable iff (reset)
            cdb_valid[k] |-> (cdb_tag[k] != '0))
            else $error("CDB lane %0d broadcasts tag 0", k);

        if (k > 0) begin : g_order   // Lanes pack from 0
            a_packed: assert property (@(posedge clock) disable iff (reset)
                cdb_valid[k] |-> cdb_valid[k-1])
                else $error("CDB lane %0d valid while lane %0d is idle", k, k - 1);
        end

        for (genvar m = k + 1; m < ooo_pkg::N; m++) begin : g_pair
            a_unique: assert property (@(posedge clock) disable iff (reset)
                !(cdb_valid[k] && cdb_valid[m] && (cdb_tag[k] == cdb_tag[m])))
                else $error("CDB lanes %0d and %0d carry the same tag", k, m);
        end
    end

    a_reset_quiet: assert property (@(posedge clock)
        reset |=> ((cdb_valid == '0) && !almost_full))
        else $error("CDB or almost_full active right after reset");

endmodule

bind issue_core issue_core_chk chk (
    .clock       (clock),
    .reset       (reset),
    .almost_full (almost_full),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag)
);

// ==== testbench/issue_core_tb.sv ====
`timescale 1ns/1ns

module issue_core_tb;
    localparam int NL        = ooo_pkg::N;
    localparam int XLEN      = ooo_pkg::XLEN;
    localparam int TAG_W     = ooo_pkg::TAG_W;
    localparam int MAX_INSTR = 63;

    logic                            clock;
    logic                            reset;
    logic [NL-1:0]                   dispatch_valid;
    ooo_pkg::fu_kind_e [NL-1:0]      dispatch_fu;
    ooo_pkg::alu_func_e [NL-1:0]     dispatch_func;
    logic [NL-1:0]                   op1_ready;
    ooo_pkg::operand_u [NL-1:0]      op1;
    logic [NL-1:0]                   op2_ready;
    ooo_pkg::operand_u [NL-1:0]      op2;
    logic [NL-1:0][TAG_W-1:0]        dest_tag;
    logic                            almost_full;
    logic [NL-1:0]                   cdb_valid;
    logic [NL-1:0][TAG_W-1:0]        cdb_tag;
    logic [NL-1:0][XLEN-1:0]         cdb_value;

    // Instruction i writes tag i+1 and a source of 0 means the immediate
    ooo_pkg::alu_func_e prog_func [MAX_INSTR];
    int                 prog_src1 [MAX_INSTR];
    int                 prog_src2 [MAX_INSTR];
    logic [XLEN-1:0]    prog_imm1 [MAX_INSTR];
    logic [XLEN-1:0]    prog_imm2 [MAX_INSTR];
    int                 prog_len;

    logic [XLEN-1:0] expected [int];   // Reference value per tag
    bit              seen [int];
    string           test_name;
    int              broadcasts;
    int              cycle_count = 0;
    int              deadline = 0;
    bit              saw_full;

    issue_core #(
        .SIZE        (8),
        .ALERT_DEPTH (ooo_pkg::N),
        .NUM_ALU     (2),
        .MULT_STAGES (3)
    ) UUT (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_fu    (dispatch_fu),
        .dispatch_func  (dispatch_func),
        .op1_ready      (op1_ready),
        .op1            (op1),
        .op2_ready      (op2_ready),
        .op2            (op2),
        .dest_tag       (dest_tag),
        .almost_full    (almost_full),
        .cdb_valid      (cdb_valid),
        .cdb_tag        (cdb_tag),
        .cdb_value      (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    function automatic logic [XLEN-1:0] ref_result(ooo_pkg::alu_func_e func,
                                                   logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        case (func)
            ooo_pkg::SUB: return a - b;
            ooo_pkg::AND: return a & b;
            ooo_pkg::XOR: return a ^ b;
            ooo_pkg::MUL: return a * b;   // Low word
            default:      return a + b;
        endcase
    endfunction

    task automatic check_result(logic [TAG_W-1:0] tag, logic [XLEN-1:0] exp,
                                logic [XLEN-1:0] act);
        if (exp !== act) begin
            fail_run($sformatf("ERR %s tag %0d: expected %h, actual %h",
                               test_name, tag, exp, act));
        end
    endtask

    task automatic check_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            fail_run($sformatf("ERR %s %s: expected %b, actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_broadcast(logic [TAG_W-1:0] tag, logic [XLEN-1:0] value);
        if (expected.exists(int'(tag)) == 0) begin
            fail_run($sformatf("Test %s: tag %0d came on the CDB but was never dispatched",
                               test_name, tag));
        end else if (seen.exists(int'(tag)) != 0) begin
            fail_run($sformatf("Test %s: tag %0d was broadcast more than once", test_name, tag));
        end else begin
            check_result(tag, expected[int'(tag)], value);
            seen[int'(tag)] = 1'b1;
            broadcasts++;
        end
    endtask

    // CDB lanes settle by mid-cycle
    always @(negedge clock) begin
        if (!reset) begin
            for (int k = 0; k < NL; k++) begin
                if (cdb_valid[k]) begin
                    check_broadcast(cdb_tag[k], cdb_value[k]);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > deadline) begin
            fail_run($sformatf("Timeout in test %s: results missing after cycle %0d",
                               test_name, cycle_count));
        end
    end

    function automatic ooo_pkg::alu_func_e random_func(bit with_mul);
        int pick;
        pick = int'($urandom % (with_mul ? 32'd5 : 32'd4));
        case (pick)
            0:       return ooo_pkg::ADD;
            1:       return ooo_pkg::SUB;
            2:       return ooo_pkg::AND;
            3:       return ooo_pkg::XOR;
            default: return ooo_pkg::MUL;
        endcase
    endfunction

    function automatic int earlier_tag();
        if (prog_len == 0) begin
            return 0;
        end
        return 1 + int'($urandom % 32'(prog_len));
    endfunction

    task automatic new_test();
        expected.delete();
        seen.delete();
        prog_len   = 0;
        broadcasts = 0;
        saw_full   = 1'b0;
    endtask

    task automatic add_instr(ooo_pkg::alu_func_e func, int s1, int s2);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        prog_func[prog_len] = func;
        prog_src1[prog_len] = s1;
        prog_src2[prog_len] = s2;
        prog_imm1[prog_len] = $urandom;
        prog_imm2[prog_len] = $urandom;
        a = (s1 != 0) ? expected[s1] : prog_imm1[prog_len];
        b = (s2 != 0) ? expected[s2] : prog_imm2[prog_len];
        expected[prog_len + 1] = ref_result(func, a, b);
        prog_len++;
    endtask

    // Value once the producer was seen and its tag before that
    function automatic ooo_pkg::operand_u operand_for(int src, logic [XLEN-1:0] imm);
        ooo_pkg::operand_u o;
        o.value = imm;
        if (src != 0) begin
            if (seen.exists(src) != 0) begin
                o.value = expected[src];
            end else begin
                o.value   = '0;
                o.src.tag = TAG_W'(src);
            end
        end
        return o;
    endfunction

    function automatic logic operand_ready(int src);
        return (src == 0) || (seen.exists(src) != 0);
    endfunction

    task automatic idle_lanes();
        dispatch_valid = '0;
        op1_ready      = '0;
        op2_ready      = '0;
        op1            = '0;
        op2            = '0;
        dest_tag       = '0;
        for (int k = 0; k < NL; k++) begin
            dispatch_fu[k]   = ooo_pkg::FU_ALU;
            dispatch_func[k] = ooo_pkg::ADD;
        end
    endtask

    task automatic drive_lane(int k, int i);
        dispatch_valid[k] = 1'b1;
        dispatch_fu[k]    = (prog_func[i] == ooo_pkg::MUL) ? ooo_pkg::FU_MULT : ooo_pkg::FU_ALU;
        dispatch_func[k]  = prog_func[i];
        op1[k]            = operand_for(prog_src1[i], prog_imm1[i]);
        op1_ready[k]      = operand_ready(prog_src1[i]);
        op2[k]            = operand_for(prog_src2[i], prog_imm2[i]);
        op2_ready[k]      = operand_ready(prog_src2[i]);
        dest_tag[k]       = TAG_W'(i + 1);
    endtask

    task automatic run_test(string name, bit random_lanes);
        int next;
        int lanes;
        bit held;
        test_name = name;
        deadline  = cycle_count + 64 * prog_len + 200;
        next      = 0;
        while (next < prog_len) begin
            lanes = random_lanes ? int'($urandom % (NL + 1)) : NL;
            if (lanes > prog_len - next) begin
                lanes = prog_len - next;
            end
            do begin   // Group held while almost_full with operands refreshed
                held = almost_full;
                if (held) begin
                    saw_full = 1'b1;
                end
                for (int k = 0; k < NL; k++) begin
                    if (k < lanes) begin
                        drive_lane(k, next + k);
                    end else begin
                        dispatch_valid[k] = 1'b0;
                    end
                end
                @(posedge clock);
                #1;
            end while (held);
            next += lanes;
        end
        idle_lanes();
        while (broadcasts < prog_len) begin
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        void'($urandom(32'he4fea79f));
        reset     = 1'b1;
        test_name = "after_reset";
        deadline  = 16 + 200;
        idle_lanes();
        new_test();
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        check_flag("almost_full", 1'b0, almost_full);
        check_flag("cdb_valid", 1'b0, |cdb_valid);

        for (int i = 0; i < 12; i++) begin
            add_instr(random_func(1'b0), 0, 0);
        end
        run_test("independent_alu", 1'b0);

        new_test();
        for (int i = 0; i < 16; i++) begin
            add_instr(random_func(1'b0), prog_len, (i % 3 == 0) ? 0 : earlier_tag());
        end
        run_test("dependency_chain", 1'b0);

        new_test();
        for (int i = 0; i < 12; i++) begin
            add_instr(ooo_pkg::MUL, 0, 0);
        end
        run_test("mul_burst", 1'b0);

        new_test();
        for (int i = 0; i < 20; i++) begin
            add_instr((i % 2 == 0) ? ooo_pkg::MUL : random_func(1'b0), 0, 0);
        end
        run_test("cdb_pressure", 1'b0);

        new_test();
        for (int i = 0; i < 40; i++) begin   // Serial chain keeps entries waiting
            add_instr((i % 3 == 0) ? ooo_pkg::MUL : random_func(1'b0), prog_len, 0);
        end
        run_test("dispatch_flood", 1'b0);
        check_flag("almost_full seen", 1'b1, saw_full);

        new_test();
        for (int i = 0; i < 60; i++) begin
            add_instr(random_func(1'b1), ($urandom % 2 == 0) ? earlier_tag() : 0,
                      ($urandom % 2 == 0) ? earlier_tag() : 0);
        end
        run_test("random_mix", 1'b1);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/ooo_pkg.sv
hw/psel_gen.sv
hw/rs.sv
hw/alu_fu.sv
hw/mult_fu.sv
hw/cdb_arb.sv
hw/issue_core.sv
testbench/issue_core_chk.sv
testbench/issue_core_tb.sv

// ==== Makefile ====
TOP = issue_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim

clean:
	rm -rf obj_dir
